/* common/game_pkg.sv */
package game_pkg;

	//////////////////////////////
	// game states and outcomes
	//////////////////////////////

	// round state, also sent over the link
	typedef enum logic [1:0]
	{
		ST_IDLE   = 2'd0, // waiting for start
		ST_PLAY   = 2'd1, // timed round running
		ST_RESULT = 2'd2  // banner on screen
	} game_state_e;

	// outcome seen from one board, same code as the link
	typedef enum logic [1:0]
	{
		OUT_WIN  = 2'd0,
		OUT_LOSE = 2'd1,
		OUT_TIE  = 2'd2,
		OUT_NONE = 2'd3 // no round result yet
	} outcome_e;

	typedef logic [7:0] score_t; // one board's score
	typedef logic [7:0] glyph_t; // one lcd character code

	localparam score_t SCORE_MAX = 8'hFF; // saturation point

	//////////////////////////////
	// screen layout and glyphs
	//////////////////////////////

	localparam int ROW_LEN    = 16; // characters per lcd row
	localparam int COL_W      = 4;  // column address width
	localparam int BANNER_POS = 4;  // first banner column
	localparam int BANNER_LEN = 4;  // banner glyph count

	localparam logic [COL_W-1:0] COL_LAST = COL_W'(ROW_LEN - 1);

	// index 0 is the leftmost character
	typedef glyph_t [ROW_LEN-1:0] screen_row_t;

	localparam glyph_t FONT_NONE = 8'h20; // blank

	// custom cgram glyphs for the banners
	localparam glyph_t GRAPH_WINNER_1 = 8'h00;
	localparam glyph_t GRAPH_WINNER_2 = 8'h01;
	localparam glyph_t GRAPH_WINNER_3 = 8'h02;
	localparam glyph_t GRAPH_WINNER_4 = 8'h03;
	localparam glyph_t GRAPH_LOSER_1  = 8'h04;
	localparam glyph_t GRAPH_LOSER_2  = 8'h05;
	localparam glyph_t GRAPH_LOSER_3  = 8'h06;
	localparam glyph_t GRAPH_LOSER_4  = 8'h07;
	localparam glyph_t GRAPH_TIE_1    = 8'h08;
	localparam glyph_t GRAPH_TIE_2    = 8'h09;
	localparam glyph_t GRAPH_TIE_3    = 8'h0A;
	localparam glyph_t GRAPH_TIE_4    = 8'h0B;

	localparam screen_row_t BLANK_ROW = {ROW_LEN{FONT_NONE}}; // all blanks

	//////////////////////////////
	// round timing in ticks
	//////////////////////////////

	localparam int PLAY_TICKS   = 20; // round length
	localparam int RESULT_TICKS = 7;  // banner hold
	localparam int PLAY_CNT_W   = 5;
	localparam int HOLD_CNT_W   = 3;

	localparam logic [PLAY_CNT_W-1:0] PLAY_LAST = PLAY_CNT_W'(PLAY_TICKS - 1);
	localparam logic [HOLD_CNT_W-1:0] HOLD_LAST = HOLD_CNT_W'(RESULT_TICKS - 1);

	//////////////////////////////
	// wishbone classic to lcd
	//////////////////////////////

	typedef struct packed
	{
		logic             cyc;
		logic             stb;
		logic             we;
		logic [COL_W-1:0] adr; // lcd column
		glyph_t           dat; // character code
	} wb_m2s_t;

	typedef struct packed
	{
		logic ack;
	} wb_s2m_t;

endpackage

/* hw/round_control.sv */
`timescale 1ns/1ns

module round_control
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  tick,        // one-second enable
	input  logic                  start,       // begin a round
	input  logic                  result_done, // banner hold over
	output game_pkg::game_state_e state
);

	game_pkg::game_state_e           state_nxt;
	logic [game_pkg::PLAY_CNT_W-1:0] play_cnt; // ticks seen in play
	logic                            play_end; // last tick of the round

	assign play_end = tick && (play_cnt == game_pkg::PLAY_LAST);

	//////////////////////////////
	// play period counter
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			play_cnt <= '0;
		else if (state != game_pkg::ST_PLAY)
			play_cnt <= '0; // fresh count each round
		else if (play_end)
			play_cnt <= '0;
		else if (tick)
			play_cnt <= play_cnt + 1'b1;
	end

	//////////////////////////////
	// game fsm
	//////////////////////////////

	always_comb
	begin
		state_nxt = state; // hold by default
		unique case (state)
			game_pkg::ST_IDLE:
			begin
				if (start)
					state_nxt = game_pkg::ST_PLAY;
			end
			game_pkg::ST_PLAY:
			begin
				// start pulses here are dropped
				if (play_end)
					state_nxt = game_pkg::ST_RESULT;
			end
			game_pkg::ST_RESULT:
			begin
				if (result_done)
					state_nxt = game_pkg::ST_IDLE; // back for the next round
			end
			default:
			begin
				state_nxt = game_pkg::ST_IDLE; // unused code, recover
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= game_pkg::ST_IDLE;
		else
			state <= state_nxt;
	end

endmodule

/* hw/score_keeper.sv */
`timescale 1ns/1ns

module score_keeper
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  game_pkg::game_state_e state,        // from round control
	input  logic                  hit,          // one pulse per hit
	input  game_pkg::score_t      score_main,   // from the link
	output game_pkg::score_t      score_sec,    // local player's score
	output game_pkg::score_t      score_main_q  // registered main score
);

	logic sat; // counter at its ceiling

	assign sat = (score_sec == game_pkg::SCORE_MAX);

	//////////////////////////////
	// secondary score
	//////////////////////////////

	// idle keeps it at zero, so the edge into play starts from zero
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			score_sec <= '0;
		else if (state == game_pkg::ST_IDLE)
			score_sec <= '0;
		else if ((state == game_pkg::ST_PLAY) && hit && !sat)
			score_sec <= score_sec + 1'b1; // stops at 255
	end

	//////////////////////////////
	// main score from link
	//////////////////////////////

	// one cycle late, zero before the round
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			score_main_q <= '0;
		else if (state == game_pkg::ST_IDLE)
			score_main_q <= '0;
		else
			score_main_q <= score_main; // sampled every cycle
	end

endmodule

/* result/result_screen.sv */
`timescale 1ns/1ns

module result_screen
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  tick,          // one-second enable
	input  game_pkg::game_state_e state,
	input  game_pkg::score_t      score_main,    // main board, registered
	input  game_pkg::score_t      score_sec,     // this board
	output game_pkg::outcome_e    win_lose_main, // outcome for main board
	output logic                  result_done,   // end of banner hold
	output game_pkg::screen_row_t row            // lcd row to show
);

	logic [game_pkg::HOLD_CNT_W-1:0]                   hold_cnt; // ticks in result
	game_pkg::glyph_t [game_pkg::BANNER_LEN-1:0]       banner;   // four banner glyphs
	logic                                              in_result;

	assign in_result = (state == game_pkg::ST_RESULT);

	//////////////////////////////
	// banner hold timer
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hold_cnt    <= '0;
			result_done <= 1'b0;
		end
		else
		begin
			result_done <= 1'b0; // single-cycle pulse
			if (!in_result)
				hold_cnt <= '0;
			else if (tick)
			begin
				if (hold_cnt == game_pkg::HOLD_LAST)
				begin
					hold_cnt    <= '0;
					result_done <= 1'b1; // seventh tick seen
				end
				else
					hold_cnt <= hold_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////
	// outcome judge
	//////////////////////////////

	always_comb
	begin
		if (!in_result)
			win_lose_main = game_pkg::OUT_NONE;
		else if (score_main > score_sec)
			win_lose_main = game_pkg::OUT_WIN;
		else if (score_main < score_sec)
			win_lose_main = game_pkg::OUT_LOSE;
		else
			win_lose_main = game_pkg::OUT_TIE; // equal scores
	end

	//////////////////////////////
	// banner row
	//////////////////////////////

	// local banner is the mirror of the main board's outcome
	always_comb
	begin
		unique case (win_lose_main)
			game_pkg::OUT_WIN:  banner = {game_pkg::GRAPH_LOSER_4, game_pkg::GRAPH_LOSER_3,
						game_pkg::GRAPH_LOSER_2, game_pkg::GRAPH_LOSER_1};
			game_pkg::OUT_LOSE: banner = {game_pkg::GRAPH_WINNER_4, game_pkg::GRAPH_WINNER_3,
						game_pkg::GRAPH_WINNER_2, game_pkg::GRAPH_WINNER_1};
			game_pkg::OUT_TIE:  banner = {game_pkg::GRAPH_TIE_4, game_pkg::GRAPH_TIE_3,
						game_pkg::GRAPH_TIE_2, game_pkg::GRAPH_TIE_1};
			default:            banner = {game_pkg::BANNER_LEN{game_pkg::FONT_NONE}};
		endcase
	end

	always_comb
	begin
		row = game_pkg::BLANK_ROW; // blanks everywhere else
		for (int i = 0; i < game_pkg::BANNER_LEN; i++)
			row[game_pkg::BANNER_POS + i] = banner[i]; // columns 4 to 7
	end

endmodule

/* display/lcd_row_writer.sv */
`timescale 1ns/1ns

module lcd_row_writer
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  game_pkg::screen_row_t row,      // row wanted on screen
	output game_pkg::wb_m2s_t     lcd_wb_o, // to lcd controller
	input  game_pkg::wb_s2m_t     lcd_wb_i  // ack back
);

	// writer fsm
	typedef enum logic [1:0]
	{
		W_IDLE = 2'd0, // screen up to date
		W_REQ  = 2'd1, // bus cycle open, waiting on ack
		W_GAP  = 2'd2  // cyc low between writes
	} wr_state_e;

	wr_state_e                    wstate;
	logic [game_pkg::COL_W-1:0]   col;      // column being written
	game_pkg::screen_row_t        last_row; // what the lcd now shows
	game_pkg::screen_row_t        pass_row; // row frozen for this pass
	logic                         row_dirty;
	logic                         wr_ack;   // current write accepted

	assign row_dirty = (row != last_row);
	assign wr_ack    = (wstate == W_REQ) && lcd_wb_i.ack;

	//////////////////////////////
	// pass control
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wstate   <= W_IDLE;
			col      <= '0;
			last_row <= game_pkg::BLANK_ROW; // lcd starts blank
		end
		else
		begin
			unique case (wstate)
				W_IDLE:
				begin
					if (row_dirty)
					begin
						col    <= '0; // always from the left
						wstate <= W_REQ;
					end
				end
				W_REQ:
				begin
					if (wr_ack)
					begin
						col    <= col + 1'b1; // wraps to 0 after 15
						wstate <= W_GAP;
						if (col == game_pkg::COL_LAST)
							last_row <= pass_row; // pass complete
					end
				end
				W_GAP:
				begin
					// col back at 0 means the pass wrapped
					if (col == '0)
						wstate <= W_IDLE;
					else
						wstate <= W_REQ;
				end
				default:
				begin
					wstate <= W_IDLE;
				end
			endcase
		end
	end

	// later row changes wait for the next pass
	always_ff @(posedge clk)
	begin
		if ((wstate == W_IDLE) && row_dirty)
			pass_row <= row;
	end

	//////////////////////////////
	// bus drive
	//////////////////////////////

	// all fields come from registers, steady until ack
	always_comb
	begin
		lcd_wb_o.cyc = (wstate == W_REQ);
		lcd_wb_o.stb = (wstate == W_REQ);
		lcd_wb_o.we  = (wstate == W_REQ); // writes only
		lcd_wb_o.adr = col;
		lcd_wb_o.dat = pass_row[col];
	end

endmodule

/* hw/game_secondary_top.sv */
`timescale 1ns/1ns

module game_secondary_top
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  tick,          // one pulse per second
	input  logic                  start,         // begin a round
	input  logic                  hit,           // secondary player hit
	input  game_pkg::score_t      score_main,    // main score from link
	output game_pkg::game_state_e game_state,    // to link
	output game_pkg::outcome_e    win_lose_main, // to link
	output logic                  result_done,   // banner hold over
	output game_pkg::wb_m2s_t     lcd_wb_o,      // lcd controller bus
	input  game_pkg::wb_s2m_t     lcd_wb_i
);

	game_pkg::score_t      score_sec;    // local count
	game_pkg::score_t      score_main_q; // main score after register
	game_pkg::screen_row_t row;          // composed banner row

	//////////////////////////////
	// stages
	//////////////////////////////

	round_control u_round_control
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.tick        (tick),
		.start       (start),
		.result_done (result_done),
		.state       (game_state)
	);

	score_keeper u_score_keeper
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.state        (game_state),
		.hit          (hit),
		.score_main   (score_main),
		.score_sec    (score_sec),
		.score_main_q (score_main_q)
	);

	result_screen u_result_screen
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.tick          (tick),
		.state         (game_state),
		.score_main    (score_main_q),
		.score_sec     (score_sec),
		.win_lose_main (win_lose_main),
		.result_done   (result_done),
		.row           (row)
	);

	lcd_row_writer u_lcd_row_writer
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.row      (row),
		.lcd_wb_o (lcd_wb_o),
		.lcd_wb_i (lcd_wb_i)
	);

endmodule

/* testbench/tb_game_secondary.sv */
`timescale 1ns/1ns

module tb_game_secondary;

	localparam logic [31:0] SEED     = 32'h2b9425e8;
	localparam int          HALF_CLK = 20;   // 40 ns period
	localparam int          ROUNDS   = 12;
	localparam int          ROUND_TO = 3000; // cycles per round, worst case about 600
	localparam int          DRAIN_TO = 400;  // two passes at the slowest ack

	logic                  clk;
	logic                  rst_n;
	logic                  tick;
	logic                  start;
	logic                  hit;
	game_pkg::score_t      score_main;
	game_pkg::game_state_e game_state;
	game_pkg::outcome_e    win_lose_main;
	logic                  result_done;
	game_pkg::wb_m2s_t     lcd_wb_o;
	game_pkg::wb_s2m_t     lcd_wb_i;

	logic [31:0]                rng_main;  // stimulus stream
	logic [31:0]                rng_ack;   // ack delay stream
	logic                       busy;      // write seen, ack pending
	int                         ack_wait;
	logic [game_pkg::COL_W-1:0] wr_col;    // next column expected on the bus
	logic [game_pkg::COL_W-1:0] held_adr;
	game_pkg::glyph_t           held_dat;
	game_pkg::screen_row_t      screen;    // what the lcd would show
	game_pkg::screen_row_t      exp_rows[$];

	game_secondary_top uut
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.tick          (tick),
		.start         (start),
		.hit           (hit),
		.score_main    (score_main),
		.game_state    (game_state),
		.win_lose_main (win_lose_main),
		.result_done   (result_done),
		.lcd_wb_o      (lcd_wb_o),
		.lcd_wb_i      (lcd_wb_i)
	);

	initial
	begin
		clk = 1'b0;
		forever #HALF_CLK clk = ~clk;
	end

	//////////////////////////////
	// helpers and game model
	//////////////////////////////

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (actual !== expected)
			report_failure($sformatf("ERROR %s expected %0h actual %0h", name, expected, actual));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] draw_random();
		rng_main = xorshift(rng_main);
		return rng_main;
	endfunction

	// outcome as the main board sees it
	function automatic game_pkg::outcome_e judge(input game_pkg::score_t m,
		input game_pkg::score_t s);
		if (m > s)
			return game_pkg::OUT_WIN;
		else if (m < s)
			return game_pkg::OUT_LOSE;
		return game_pkg::OUT_TIE;
	endfunction

	function automatic game_pkg::screen_row_t banner_row(input game_pkg::outcome_e o);
		game_pkg::screen_row_t r;
		game_pkg::glyph_t      first;
		for (int i = 0; i < game_pkg::ROW_LEN; i++)
			r[i] = game_pkg::FONT_NONE;
		case (o)
			game_pkg::OUT_WIN:  first = game_pkg::GRAPH_LOSER_1;  // main ahead, we lost
			game_pkg::OUT_LOSE: first = game_pkg::GRAPH_WINNER_1;
			game_pkg::OUT_TIE:  first = game_pkg::GRAPH_TIE_1;
			default:            return r; // no banner
		endcase
		for (int i = 0; i < 4; i++)
			r[game_pkg::BANNER_POS + i] = first + i; // glyph codes run in order
		return r;
	endfunction

	//////////////////////////////
	// wishbone lcd responder
	//////////////////////////////

	always @(negedge clk)
	begin
		if (rst_n)
		begin
			check_value("wb cyc", lcd_wb_o.stb, lcd_wb_o.cyc);
			if (lcd_wb_i.ack)
			begin
				lcd_wb_i.ack = 1'b0;
				check_value("wb gap", 1'b0, lcd_wb_o.stb); // idle cycle after each ack
			end
			else if (lcd_wb_o.stb)
			begin
				if (!busy)
				begin
					busy     = 1'b1;
					held_adr = lcd_wb_o.adr;
					held_dat = lcd_wb_o.dat;
					rng_ack  = xorshift(rng_ack);
					ack_wait = rng_ack % 6; // 0 to 5 cycles
					check_value("wb we", 1'b1, lcd_wb_o.we);
					check_value("wb column", wr_col, lcd_wb_o.adr);
				end
				check_value("wb adr held", held_adr, lcd_wb_o.adr);
				check_value("wb dat held", held_dat, lcd_wb_o.dat);
				if (ack_wait == 0)
				begin
					lcd_wb_i.ack         = 1'b1;
					busy                 = 1'b0;
					screen[lcd_wb_o.adr] = lcd_wb_o.dat;
					wr_col               = wr_col + 1'b1;
					if (lcd_wb_o.adr == game_pkg::COL_LAST)
					begin
						if (exp_rows.size() == 0)
							report_failure("LCD writer ran a pass with no row change");
						check_value("lcd row", exp_rows.pop_front(), screen);
					end
				end
				else
					ack_wait--;
			end
		end
	end

	//////////////////////////////
	// one round
	//////////////////////////////

	task automatic play_round(input int r);
		int                    tick_gap;
		int                    hit_gap;
		int                    tick_phase;
		int                    hit_phase;
		int                    hits_left;
		int                    hit_cnt;   // hits that land in play
		int                    play_ticks;
		int                    res_ticks;
		int                    cycles;
		logic                  long_round;
		logic                  tie_round;
		logic                  in_round;
		logic                  stray_hit;
		logic [31:0]           v;
		game_pkg::score_t      main_sc;
		game_pkg::score_t      exp_sec;
		game_pkg::outcome_e    exp_out;
		game_pkg::game_state_e prev;
		begin
			long_round = (r % 4 == 3); // enough play time to pass 255
			tie_round  = (r % 3 == 1);
			tick_gap   = long_round ? 20 : 3 + draw_random() % 4;
			hit_gap    = (long_round || tie_round) ? 1 : 1 + draw_random() % 3;
			hits_left  = long_round ? 256 + draw_random() % 80 : draw_random() % 60;
			v          = draw_random();
			main_sc    = v[7:0];
			if (tie_round)
				main_sc = (hits_left > 255) ? 8'hFF : hits_left[7:0];

			// stray hits in idle
			for (int i = 0; i < 4; i++)
			begin
				@(negedge clk);
				check_value("idle state", game_pkg::ST_IDLE, game_state);
				check_value("idle outcome", game_pkg::OUT_NONE, win_lose_main);
				v   = draw_random();
				hit = v[3];
			end
			@(negedge clk);
			hit        = 1'b0;
			start      = 1'b1;
			score_main = main_sc; // held for the whole round
			@(negedge clk);
			start = 1'b0;
			check_value("state after start", game_pkg::ST_PLAY, game_state);

			prev       = game_pkg::ST_PLAY;
			in_round   = 1'b1;
			cycles     = 0;
			tick_phase = 0;
			hit_phase  = 0;
			hit_cnt    = 0;
			play_ticks = 0;
			res_ticks  = 0;
			while (in_round)
			begin
				tick       = (tick_phase == tick_gap - 1);
				tick_phase = tick ? 0 : tick_phase + 1;
				stray_hit  = tie_round && (game_state == game_pkg::ST_RESULT); // would break tie
				hit        = ((hits_left > 0) || stray_hit) && (hit_phase == 0);
				hit_phase  = (hit_phase + 1) % hit_gap;
				if (hit)
					hits_left--;
				if (hit && (game_state == game_pkg::ST_PLAY))
					hit_cnt++;
				if (tick && (game_state == game_pkg::ST_PLAY))
					play_ticks++;
				if (tick && (game_state == game_pkg::ST_RESULT))
					res_ticks++;
				@(negedge clk);
				cycles++;
				if (cycles > ROUND_TO)
					report_failure("round did not get back to idle in time");

				exp_sec = (hit_cnt > 255) ? 8'hFF : hit_cnt[7:0]; // saturating
				exp_out = judge(main_sc, exp_sec);
				case (game_state)
					game_pkg::ST_PLAY:
					begin
						check_value("play outcome", game_pkg::OUT_NONE, win_lose_main);
						check_value("play result done", 1'b0, result_done);
					end
					game_pkg::ST_RESULT:
					begin
						if (prev == game_pkg::ST_PLAY)
						begin
							check_value("play length", game_pkg::PLAY_TICKS, play_ticks);
							exp_rows.push_back(banner_row(exp_out));
							exp_rows.push_back(banner_row(game_pkg::OUT_NONE)); // blank after
						end
						check_value("result outcome", exp_out, win_lose_main);
						check_value("result done", res_ticks == game_pkg::RESULT_TICKS,
							result_done);
					end
					default:
					begin
						check_value("state before idle", game_pkg::ST_RESULT, prev);
						check_value("result done after", 1'b0, result_done);
						in_round = 1'b0;
					end
				endcase
				prev = game_state;
			end
			tick = 1'b0;
			hit  = 1'b0;

			// let both lcd passes finish
			cycles = 0;
			while ((exp_rows.size() != 0) || lcd_wb_o.cyc)
			begin
				@(negedge clk);
				check_value("state while draining", game_pkg::ST_IDLE, game_state);
				cycles++;
				if (cycles > DRAIN_TO)
					report_failure("LCD writer did not finish its passes in time");
			end
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial
	begin
		rng_main   = SEED;
		rng_ack    = {SEED[15:0], SEED[31:16]};
		rst_n      = 1'b0;
		tick       = 1'b0;
		start      = 1'b0;
		hit        = 1'b0;
		score_main = '0;
		lcd_wb_i   = '0;
		busy       = 1'b0;
		ack_wait   = 0;
		wr_col     = '0;
		screen     = banner_row(game_pkg::OUT_NONE); // lcd powers up blank
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("reset state", game_pkg::ST_IDLE, game_state);
		check_value("reset outcome", game_pkg::OUT_NONE, win_lose_main);
		check_value("reset result done", 1'b0, result_done);
		check_value("reset cyc", 1'b0, lcd_wb_o.cyc);
		check_value("reset stb", 1'b0, lcd_wb_o.stb);
		for (int r = 0; r < ROUNDS; r++)
			play_round(r);
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* game_secondary_top.f */
common/game_pkg.sv
hw/round_control.sv
hw/score_keeper.sv
result/result_screen.sv
display/lcd_row_writer.sv
hw/game_secondary_top.sv
testbench/tb_game_secondary.sv

/* Bender.yml */
package:
  name: game_secondary

sources:
  - common/game_pkg.sv
  - hw/round_control.sv
  - hw/score_keeper.sv
  - result/result_screen.sv
  - display/lcd_row_writer.sv
  - hw/game_secondary_top.sv
  - target: test
    files:
      - testbench/tb_game_secondary.sv
